//--- hw/spi_mem_pkg.sv
// spi_mem_pkg
// Shared sizes, FSM state encoding and the sclk timing rule for the SPI
// slave memory and its testbench.

package spi_mem_pkg;

   // the command byte carries a seven bit address and a read/write bit.
   localparam int addr_width = 7;

   // byte width, which is also the shift register length.
   localparam int data_width = 8;

   // number of bytes behind the SPI port.
   localparam int mem_depth = 2 ** addr_width;

   // the bit counter must reach data_width - 1.
   localparam int bit_count_width = 4;

   // flops between an asynchronous pin and the first use of its value.
   localparam int sync_stages = 2;

   // sclk must stay high and stay low for at least this many clk cycles.
   // The conditioner adds sync_stages + 1 cycles of latency, and the FSM
   // needs two more cycles after the command byte to load read data,
   // so four cycles per phase leaves margin on both sides.
   localparam int min_sclk_phase = 4;

   // transaction states.
   // idle        waits for cs to fall.
   // get_addr    collects the command byte.
   // decode      latches the address and looks at the read/write bit.
   // read_load   copies the addressed byte into the shift register.
   // read_out    drives miso until cs rises.
   // write_data  collects the data byte.
   // write_mem   stores the data byte.
   // done        waits for cs to rise.
   typedef enum logic [2:0] {
      idle       = 3'd0,
      get_addr   = 3'd1,
      decode     = 3'd2,
      read_load  = 3'd3,
      read_out   = 3'd4,
      write_data = 3'd5,
      write_mem  = 3'd6,
      done       = 3'd7
   } spi_state_t;

endpackage

//--- hw/input_conditioner.sv
// input_conditioner
// Brings one asynchronous pin into the clk domain through a short
// synchronizer chain and reports its level plus one-cycle rise and fall
// pulses. Level and pulses appear together, three cycles after the pin.

`timescale 1ns/1ps

module input_conditioner #(
   parameter logic reset_level = 1'b0
) (
   input  logic clk,
   input  logic rst,
   input  logic pin,
   output logic level,
   output logic rise,
   output logic fall
);
   import spi_mem_pkg::*;

   // synchronizer chain, bit 0 is the first stage.
   logic [sync_stages-1:0] sync_q;
   logic                   sync_out;

   assign sync_out = sync_q[sync_stages-1];

   always_ff @(posedge clk) begin
      if (rst) begin
         sync_q <= {sync_sages_fill()};
      end else begin
         sync_q <= {sync_q[sync_stages-2:0], pin};
      end
   end

   // the level register doubles as the edge detector's previous value.
   // Rise and fall compare the new sample against it, so both pulses line
   // up with the cycle in which level changes.
   always_ff @(posedge clk) begin
      if (rst) begin
         level <= reset_level;
         rise  <= 1'b0;
         fall  <= 1'b0;
      end else begin
         level <= sync_out;
         rise  <= sync_out & ~level;
         fall  <= ~sync_out & level;
      end
   end

   // every synchronizer stage starts at the pin's idle value so that no
   // false edge is reported when reset is released.
   function automatic logic [sync_stages-1:0] sync_sages_fill();
      logic [sync_stages-1:0] fill;
      fill = {sync_stages{reset_level}};
      return fill;
   endfunction

endmodule

//--- hw/shift_register.sv
// shift_register
// Byte-wide shift register for the SPI data path. It shifts serial bits in
// at bit 0, loads a whole byte in parallel, and presents its most
// significant bit as the serial output.

`timescale 1ns/1ps

module shift_register (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              shift_en,
   input  logic                              serial_in,
   input  logic                              load_en,
   input  logic [spi_mem_pkg::data_width-1:0] parallel_in,
   output logic [spi_mem_pkg::data_width-1:0] parallel_out,
   output logic                              serial_out
);
   import spi_mem_pkg::*;

   logic [data_width-1:0] data_q;

   // a parallel load takes priority over a shift in the same cycle.
   // The FSM only loads between sclk edges, so the two never meet in
   // normal operation, but the order keeps the read data intact if they do.
   always_ff @(posedge clk) begin
      if (rst) begin
         data_q <= '0;
      end else if (load_en) begin
         data_q <= parallel_in;
      end else if (shift_en) begin
         data_q <= {data_q[data_width-2:0], serial_in};
      end
   end

   assign parallel_out = data_q;

   // msb first on the wire, so the top bit is the next bit to send.
   assign serial_out = data_q[data_width-1];

endmodule

//--- hw/spi_fsm.sv
// spi_fsm
// Transaction controller for the SPI slave. It counts the command byte,
// decodes read or write, and issues one-cycle enables for the address
// register, the shift register load and the memory write.

`timescale 1ns/1ps

module spi_fsm (
   input  logic clk,
   input  logic rst,
   input  logic cs,
   input  logic cs_fall,
   input  logic bit_strobe,
   input  logic rw_bit,
   output logic addr_we,
   output logic sr_we,
   output logic dm_we,
   output logic miso_buff
);
   import spi_mem_pkg::*;

   spi_state_t                 state;
   spi_state_t                 next_state;
   logic [bit_count_width-1:0] bit_cnt;
   logic                       counting;
   logic                       last_bit;

   // the counter runs only while a byte is being collected.
   assign counting = (state == get_addr) || (state == write_data);
   assign last_bit = (bit_cnt == bit_count_width'(data_width - 1));

   always_comb begin
      next_state = state;
      if (cs) begin
         // cs high ends the transaction wherever it stands.
         next_state = idle;
      end else begin
         case (state)
            idle: begin
               if (cs_fall) begin
                  next_state = get_addr;
               end
            end
            get_addr: begin
               if (bit_strobe && last_bit) begin
                  next_state = decode;
               end
            end
            decode: begin
               // the shift register holds the full command byte here.
               if (rw_bit) begin
                  next_state = read_load;
               end else begin
                  next_state = write_data;
               end
            end
            read_load: begin
               next_state = read_out;
            end
            read_out: begin
               next_state = read_out;
            end
            write_data: begin
               if (bit_strobe && last_bit) begin
                  next_state = write_mem;
               end
            end
            write_mem: begin
               next_state = done;
            end
            done: begin
               next_state = done;
            end
            default: begin
               next_state = idle;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= idle;
      end else begin
         state <= next_state;
      end
   end

   // bit counter, cleared between bytes and whenever cs is high.
   always_ff @(posedge clk) begin
      if (rst) begin
         bit_cnt <= '0;
      end else if (cs) begin
         bit_cnt <= '0;
      end else if (counting && bit_strobe) begin
         if (last_bit) begin
            bit_cnt <= '0;
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   // each enable belongs to exactly one state, so every one-cycle state
   // yields a one-cycle pulse.
   assign addr_we   = (state == decode);
   assign sr_we     = (state == read_load);
   assign dm_we     = (state == write_mem);
   assign miso_buff = (state == read_out);

endmodule

//--- hw/data_memory.sv
// data_memory
// 128 x 8 byte store behind the SPI port. Writes land on the clock edge,
// reads are combinational from the address.

`timescale 1ns/1ps

module data_memory (
   input  logic                              clk,
   input  logic                              we,
   input  logic [spi_mem_pkg::addr_width-1:0] addr,
   input  logic [spi_mem_pkg::data_width-1:0] wdata,
   output logic [spi_mem_pkg::data_width-1:0] rdata
);
   import spi_mem_pkg::*;

   logic [data_width-1:0] mem [mem_depth];

   // contents start at zero and are left alone by rst.
   initial begin
      for (int i = 0; i < mem_depth; i++) begin
         mem[i] = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
   end

   assign rdata = mem[addr];

endmodule

//--- hw/spi_memory.sv
// spi_memory
// Mode 0 SPI slave in front of a 128 byte memory. The pins are conditioned
// into the clk domain, the FSM and shift register run side by side, and
// the address register and miso stage tie their results together.

`timescale 1ns/1ps

module spi_memory (
   input  logic clk,
   input  logic rst,
   input  logic sclk,
   input  logic cs,
   input  logic mosi,
   output logic miso,
   output logic miso_en
);
   import spi_mem_pkg::*;

   logic                  cs_level;
   logic                  cs_fall;
   logic                  sclk_rise;
   logic                  sclk_fall;
   logic                  mosi_level;
   logic                  shift_en;
   logic                  addr_we;
   logic                  sr_we;
   logic                  dm_we;
   logic                  miso_buff;
   logic [data_width-1:0] sr_parallel;
   logic                  sr_serial;
   logic [data_width-1:0] mem_rdata;
   logic [addr_width-1:0] addr_q;

   // cs idles high, sclk and mosi idle low in mode 0.
   input_conditioner #(.reset_level(1'b1)) i_cond_cs (
      .clk   (clk),
      .rst   (rst),
      .pin   (cs),
      .level (cs_level),
      .rise  (),
      .fall  (cs_fall)
   );

   input_conditioner #(.reset_level(1'b0)) i_cond_sclk (
      .clk   (clk),
      .rst   (rst),
      .pin   (sclk),
      .level (),
      .rise  (sclk_rise),
      .fall  (sclk_fall)
   );

   input_conditioner #(.reset_level(1'b0)) i_cond_mosi (
      .clk   (clk),
      .rst   (rst),
      .pin   (mosi),
      .level (mosi_level),
      .rise  (),
      .fall  ()
   );

   // mosi is sampled on sclk rise, and only while the slave is selected.
   assign shift_en = sclk_rise & ~cs_level;

   spi_fsm i_fsm (
      .clk        (clk),
      .rst        (rst),
      .cs         (cs_level),
      .cs_fall    (cs_fall),
      .bit_strobe (sclk_rise),
      .rw_bit     (sr_parallel[0]),
      .addr_we    (addr_we),
      .sr_we      (sr_we),
      .dm_we      (dm_we),
      .miso_buff  (miso_buff)
   );

   shift_register i_shift_reg (
      .clk          (clk),
      .rst          (rst),
      .shift_en     (shift_en),
      .serial_in    (mosi_level),
      .load_en      (sr_we),
      .parallel_in  (mem_rdata),
      .parallel_out (sr_parallel),
      .serial_out   (sr_serial)
   );

   // the upper seven bits of the command byte are the address.
   always_ff @(posedge clk) begin
      if (addr_we) begin
         addr_q <= sr_parallel[data_width-1:1];
      end
   end

   data_memory i_mem (
      .clk   (clk),
      .we    (dm_we),
      .addr  (addr_q),
      .wdata (sr_parallel),
      .rdata (mem_rdata)
   );

   // miso changes after each falling sclk edge, so the host can sample it
   // on the following rise. Deselecting the slave parks it low.
   always_ff @(posedge clk) begin
      if (rst) begin
         miso <= 1'b0;
      end else if (cs_level) begin
         miso <= 1'b0;
      end else if (sclk_fall) begin
         miso <= sr_serial;
      end
   end

   assign miso_en = miso_buff;

endmodule

//--- dv/spi_memory_tests.svh
// spi_memory_tests
// Directed tests for the SPI slave memory and the reference memory model
// they check against.

`ifndef SPI_MEMORY_TESTS_SVH
`define SPI_MEMORY_TESTS_SVH

localparam int sweep_writes = 40;

// transactions per test, in the order the tests run.
localparam int test_transactions = 2 + 6 + 2 * sweep_writes + 3 + 2;

// the memory starts at zero, so the model does too.
logic [data_width-1:0] ref_mem [mem_depth];

task automatic clear_reference();
   for (int i = 0; i < mem_depth; i++) begin
      ref_mem[i] = '0;
   end
endtask

task automatic write_and_track(input logic [addr_width-1:0] addr,
                               input logic [data_width-1:0] data);
   write_byte(addr, data);
   ref_mem[addr] = data;
endtask

task automatic read_and_compare(input logic [addr_width-1:0] addr);
   logic [data_width-1:0] got;
   read_byte(addr, got);
   check_value($sformatf("read data at address 0x%02h", addr), ref_mem[addr], got);
endtask

task automatic test_after_reset();
   check_bit("miso_en", 1'b0, miso_en);
   check_bit("miso", 1'b0, miso);
   read_and_compare(7'h00);
   read_and_compare(7'h7f);
endtask

task automatic test_write_readback();
   write_and_track(7'h05, 8'ha5);
   read_and_compare(7'h05);
   write_and_track(7'h40, 8'h3c);
   read_and_compare(7'h40);
   write_and_track(7'h7f, 8'hff);
   read_and_compare(7'h7f);
endtask

task automatic test_random_sweep();
   logic [addr_width-1:0] written [$];
   logic [addr_width-1:0] addr;
   logic [data_width-1:0] data;
   for (int n = 0; n < sweep_writes; n++) begin
      addr = addr_width'($random(seed));
      data = data_width'($random(seed));
      write_and_track(addr, data);
      written.push_back(addr);
   end
   // repeated addresses are read again and must show the last write.
   foreach (written[i]) begin
      read_and_compare(written[i]);
   end
endtask

// a write cut off after four data bits must leave the old byte in place.
task automatic test_aborted_write();
   write_and_track(7'h2a, 8'h5e);
   select_slave();
   send_bits({7'h2a, 1'b0}, data_width);
   send_bits(8'hc3, 4);
   deselect_slave();
   read_and_compare(7'h2a);
endtask

task automatic test_reset_keeps_memory();
   write_and_track(7'h11, 8'h96);
   rst = 1'b1;
   wait_cycles(4);
   rst = 1'b0;
   wait_cycles(2);
   check_bit("miso_en", 1'b0, miso_en);
   read_and_compare(7'h11);
endtask

`endif

//--- dv/spi_memory_tb.sv
// spi_memory_tb
// Directed testbench for the SPI slave memory. It plays the SPI host at pin
// level in mode 0, keeps a reference copy of the memory and checks each byte
// read back over miso.

`timescale 1ns/1ps

module spi_memory_tb;
   import spi_mem_pkg::*;

   localparam int clk_half_ns = 5;

   // the host holds sclk for twice the minimum phase the slave needs.
   localparam int sclk_half_cycles = 2 * min_sclk_phase;

   logic       clk;
   logic       rst;
   logic       sclk;
   logic       cs;
   logic       mosi;
   logic       miso;
   logic       miso_en;
   integer     seed;
   spi_state_t fsm_state;

   spi_memory i_dut (
      .clk     (clk),
      .rst     (rst),
      .sclk    (sclk),
      .cs      (cs),
      .mosi    (mosi),
      .miso    (miso),
      .miso_en (miso_en)
   );

   // the FSM state is shown in error lines to help locate the failing phase.
   assign fsm_state = i_dut.i_fsm.state;

   `include "spi_memory_tests.svh"

   initial begin
      clk = 1'b0;
      forever begin
         #(clk_half_ns) clk = ~clk;
      end
   end

   // every input change lands 1 ns after a rising clk edge.
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic check_value(input string name, input logic [data_width-1:0] expected,
                              input logic [data_width-1:0] actual);
      assert (actual === expected) else begin
         $display("mismatch at %0d ns: %s expected 0x%02h, got 0x%02h (fsm state %s)",
                  $time, name, expected, actual, fsm_state.name());
         $display("Errors found");
         $fatal(1, "stopping at the first failed check");
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      assert (actual === expected) else begin
         $display("mismatch at %0d ns: %s expected %b, got %b (fsm state %s)",
                  $time, name, expected, actual, fsm_state.name());
         $display("Errors found");
         $fatal(1, "stopping at the first failed check");
      end
   endtask

   task automatic select_slave();
      cs = 1'b0;
      wait_cycles(sclk_half_cycles);
   endtask

   // cs needs three cycles through the conditioner and one more for the FSM.
   task automatic deselect_slave();
      wait_cycles(sclk_half_cycles);
      cs = 1'b1;
      wait_cycles(2 * sclk_half_cycles);
   endtask

   // sends the top count bits of value, msb first, leaving sclk low.
   task automatic send_bits(input logic [data_width-1:0] value, input int count);
      for (int i = data_width - 1; i >= data_width - count; i--) begin
         mosi = value[i];
         wait_cycles(sclk_half_cycles);
         sclk = 1'b1;
         wait_cycles(sclk_half_cycles);
         sclk = 1'b0;
      end
   endtask

   // miso is sampled at the end of each low phase, just before sclk rises.
   task automatic receive_byte(output logic [data_width-1:0] value);
      for (int i = data_width - 1; i >= 0; i--) begin
         wait_cycles(sclk_half_cycles);
         value[i] = miso;
         sclk = 1'b1;
         wait_cycles(sclk_half_cycles);
         sclk = 1'b0;
      end
   endtask

   task automatic write_byte(input logic [addr_width-1:0] addr,
                             input logic [data_width-1:0] data);
      select_slave();
      send_bits({addr, 1'b0}, data_width);
      send_bits(data, data_width);
      deselect_slave();
   endtask

   task automatic read_byte(input logic [addr_width-1:0] addr,
                            output logic [data_width-1:0] data);
      select_slave();
      send_bits({addr, 1'b1}, data_width);
      check_bit("miso_en", 1'b1, miso_en);
      receive_byte(data);
      check_bit("miso_en", 1'b1, miso_en);
      deselect_slave();
      check_bit("miso_en", 1'b0, miso_en);
      check_bit("miso", 1'b0, miso);
   endtask

   // the limit allows 40 sclk half periods for each transaction of the tests.
   initial begin
      repeat (test_transactions * 40 * sclk_half_cycles) @(posedge clk);
      $display("timeout: the test sequence did not finish in the expected time");
      $display("Errors found");
      $fatal(1, "watchdog expired");
   end

   initial begin
      rst  = 1'b1;
      sclk = 1'b0;
      cs   = 1'b1;
      mosi = 1'b0;
      seed = 32'h7441;
      clear_reference();
      wait_cycles(4);
      rst = 1'b0;
      wait_cycles(2);
      test_after_reset();
      test_write_readback();
      test_random_sweep();
      test_aborted_write();
      test_reset_keeps_memory();
      $display("No errors");
      $finish;
   end

endmodule

//--- flist.f
+incdir+dv
hw/spi_mem_pkg.sv
hw/input_conditioner.sv
hw/shift_register.sv
hw/spi_fsm.sv
hw/data_memory.sv
hw/spi_memory.sv
dv/spi_memory_tb.sv

//--- Makefile
# Verilator build and run for the SPI slave memory testbench.
# Any variable below can be set on the command line, for example
#   make test BUILD_DIR=build LOG=run.log

VERILATOR ?= verilator
TOP       ?= spi_memory_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= No errors

SOURCES := $(wildcard hw/*.sv dv/*.sv dv/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS PASS_TEXT"

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# the log decides the result, since the run may stop early on an error.
test: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
